// File: common/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// instruction store size in 16-bit words
`define IMEM_DEPTH 64

// width of the word index into the store
`define IMEM_AW 6

// where fetch starts after reset
`define RESET_PC 16'h0000

// nop encoding, major opcode 00001 with all other fields zero
`define NOP_WORD 16'h0800

`endif

// File: common/fetch_pkg.sv
package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// major opcodes, the top five bits of every instruction word
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		opNop    = 5'b00001, // 0x0800 is the canonical nop
		opB      = 5'b00010, // unconditional, imm11
		opBeqz   = 5'b00100, // resolved in ex
		opBnez   = 5'b00101, // resolved in ex
		opSll    = 5'b00110, // SLL and SRA share this
		opAddiu3 = 5'b01000,
		opAddiu  = 5'b01001,
		opSltui  = 5'b01011,
		opSpOps  = 5'b01100, // ADDSP, BTEQZ, MTSP
		opLi     = 5'b01101,
		opMove   = 5'b01111,
		opLwSp   = 5'b10010,
		opLw     = 5'b10011,
		opSwSp   = 5'b11010,
		opSw     = 5'b11011,
		opAddu   = 5'b11100, // ADDU and SUBU
		opAlu    = 5'b11101, // AND, OR, CMP, JR, MFPC ...
		opIh     = 5'b11110  // MFIH / MTIH
	} opcodeE;

	////////////////////////////////////////////////////////////////////////////
	// pipeline payloads
	////////////////////////////////////////////////////////////////////////////

	// request to restart fetch somewhere else
	typedef struct packed {
		logic        valid;
		logic [15:0] target; // byte address of the new pc
	} redirectT;

	// what IF hands to ID
	typedef struct packed {
		logic        valid;  // low for bubbles and flushes
		logic [15:0] pc;
		logic [15:0] instr;
	} fetchPacketT;

endpackage

// File: fetch/pcGen.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module pcGen (
	input  logic               clk,
	input  logic               rstN,
	input  logic               stall,       // later stages not ready
	input  logic               memConflict, // data side owns the bus
	input  fetch_pkg::redirectT exRedirect, // late branch / JR from ex
	input  fetch_pkg::redirectT bRedirect,  // early B from predecode
	output logic [15:0]        pc
);

	logic [15:0] nextPc;
	logic [15:0] seqPc;

	assign seqPc = pc + 16'd4; // one word is 4 in pc units

	////////////////////////////////////////////////////////////////////////////
	// next pc selection
	////////////////////////////////////////////////////////////////////////////

	// late redirect wins over everything, even stall, since the
	// younger instructions it kills must not hold the front end
	always_comb begin
		if (exRedirect.valid) begin
			nextPc = exRedirect.target;
		end else if (stall || memConflict) begin
			nextPc = pc; // hold, the same word is fetched again
		end else if (bRedirect.valid) begin
			nextPc = bRedirect.target; // B taken right away, no bubble
		end else begin
			nextPc = seqPc;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// pc register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

// File: fetch/instructionMemory.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module instructionMemory #(
	parameter int DEPTH = `IMEM_DEPTH, // words
	parameter int AW    = `IMEM_AW     // word index width
) (
	input  logic          clk,
	input  logic          rstN,
	input  logic          progWe,      // load port write enable
	input  logic [AW-1:0] progAddr,    // word address, not byte
	input  logic [15:0]   progData,
	input  logic [15:0]   pc,          // byte address from pcGen
	input  logic          memConflict, // bus taken by the data side
	output logic [15:0]   fetchInstr
);

	// progLen counts up to DEPTH itself, so one bit wider than the index
	localparam int LW = AW + 1;

	logic [15:0]   mem [0:DEPTH-1];
	logic [LW-1:0] progLen;   // words loaded so far
	logic [LW-1:0] writeEnd;  // progAddr + 1
	logic [13:0]   wordIdx;   // pc >> 2, full width
	logic          inProgram;

	////////////////////////////////////////////////////////////////////////////
	// load port
	////////////////////////////////////////////////////////////////////////////

	assign writeEnd = {1'b0, progAddr} + 1'b1;

	// storage itself, contents survive reset
	always_ff @(posedge clk) begin
		if (progWe) begin
			mem[progAddr] <= progData;
		end
	end

	// length only grows, a rewrite inside the program keeps it
	always_ff @(posedge clk) begin
		if (!rstN) begin
			progLen <= '0;
		end else if (progWe && (writeEnd > progLen)) begin
			progLen <= writeEnd;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////////////////////

	assign wordIdx = pc[15:2]; // word index, byte offset dropped

	// anything at or past progLen is outside the program; since
	// progLen <= DEPTH this also covers pc past the array
	assign inProgram = (wordIdx < progLen);

	always_comb begin
		if (!memConflict && inProgram) begin
			fetchInstr = mem[wordIdx[AW-1:0]];
		end else begin
			fetchInstr = `NOP_WORD; // bus lost or off the end
		end
	end

endmodule

// File: fetch/branchPredecode.sv
`timescale 1ns/1ps

module branchPredecode (
	input  logic [15:0]         pc,         // address of fetchInstr
	input  logic [15:0]         fetchInstr, // already masked word
	output fetch_pkg::redirectT bRedirect
);

	fetch_pkg::opcodeE opcode;
	logic [10:0]       imm11;
	logic [15:0]       offset; // byte offset, sign extended
	logic [15:0]       seqPc;

	////////////////////////////////////////////////////////////////////////////
	// field split
	////////////////////////////////////////////////////////////////////////////

	assign opcode = fetch_pkg::opcodeE'(fetchInstr[15:11]);
	assign imm11  = fetchInstr[10:0];

	// imm counts words, so scale by 4 to match pc units
	assign offset = {{3{imm11[10]}}, imm11, 2'b00};
	assign seqPc  = pc + 16'd4; // B is relative to the next pc

	////////////////////////////////////////////////////////////////////////////
	// redirect
	////////////////////////////////////////////////////////////////////////////

	// only the unconditional B is taken here
	// BEQZ, BNEZ, BTEQZ and JR need register values, so ex resolves them
	always_comb begin
		bRedirect.valid  = (opcode == fetch_pkg::opB);
		bRedirect.target = seqPc + offset;
	end

endmodule

// File: fetch/ifIdReg.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module ifIdReg (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   stall,
	input  logic                   memConflict,
	input  fetch_pkg::redirectT    exRedirect,
	input  logic [15:0]            pc,
	input  logic [15:0]            fetchInstr,
	output fetch_pkg::fetchPacketT idPacket
);

	fetch_pkg::fetchPacketT nextPacket;

	////////////////////////////////////////////////////////////////////////////
	// next packet
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		nextPacket = idPacket; // default is hold
		if (exRedirect.valid) begin
			// flush, the word in IF is on the wrong path
			nextPacket.valid = 1'b0;
			nextPacket.pc    = exRedirect.target; // where fetch restarts
			nextPacket.instr = `NOP_WORD;
		end else if (stall) begin
			nextPacket = idPacket;
		end else if (memConflict) begin
			nextPacket.valid = 1'b0; // bubble, pc is retried next cycle
			nextPacket.pc    = pc;
			nextPacket.instr = `NOP_WORD;
		end else begin
			nextPacket.valid = 1'b1;
			nextPacket.pc    = pc;
			nextPacket.instr = fetchInstr;
		end
	end

	// whole packet is reset, ID must see a clean nop out of reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			idPacket.valid <= 1'b0;
			idPacket.pc    <= `RESET_PC;
			idPacket.instr <= `NOP_WORD;
		end else begin
			idPacket <= nextPacket;
		end
	end

endmodule

// File: hdl/fetchTop.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetchTop (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   stall,       // back-pressure from ID
	input  logic                   memConflict, // MEM stage has the bus
	input  logic                   progWe,
	input  logic [`IMEM_AW-1:0]    progAddr,
	input  logic [15:0]            progData,
	input  fetch_pkg::redirectT    exRedirect,  // one cycle pulse
	output fetch_pkg::fetchPacketT idPacket
);

	////////////////////////////////////////////////////////////////////////////
	// internal nets
	////////////////////////////////////////////////////////////////////////////

	logic [15:0]         pc;
	logic [15:0]         fetchInstr; // nop when masked
	fetch_pkg::redirectT bRedirect;  // early B target

	////////////////////////////////////////////////////////////////////////////
	// pc
	////////////////////////////////////////////////////////////////////////////

	pcGen uPcGen (
		.clk         (clk),
		.rstN        (rstN),
		.stall       (stall),
		.memConflict (memConflict),
		.exRedirect  (exRedirect),
		.bRedirect   (bRedirect),
		.pc          (pc)
	);

	// instruction store, read in the same cycle as pc
	instructionMemory #(
		.DEPTH (`IMEM_DEPTH),
		.AW    (`IMEM_AW)
	) uInstructionMemory (
		.clk         (clk),
		.rstN        (rstN),
		.progWe      (progWe),
		.progAddr    (progAddr),
		.progData    (progData),
		.pc          (pc),
		.memConflict (memConflict),
		.fetchInstr  (fetchInstr)
	);

	// B seen here feeds straight back into the pc mux
	branchPredecode uBranchPredecode (
		.pc         (pc),
		.fetchInstr (fetchInstr),
		.bRedirect  (bRedirect)
	);

	////////////////////////////////////////////////////////////////////////////
	// IF/ID boundary
	////////////////////////////////////////////////////////////////////////////

	ifIdReg uIfIdReg (
		.clk         (clk),
		.rstN        (rstN),
		.stall       (stall),
		.memConflict (memConflict),
		.exRedirect  (exRedirect),
		.pc          (pc),
		.fetchInstr  (fetchInstr),
		.idPacket    (idPacket)
	);

endmodule

// File: dv/fetch_asserts.sv
`timescale 1ns/1ps

module fetch_asserts (
	input logic                   clk,
	input logic                   rstN,
	input logic                   stall,
	input logic                   memConflict,
	input fetch_pkg::redirectT    exRedirect,
	input logic [15:0]            pc,
	input fetch_pkg::fetchPacketT idPacket
);

	int failCount = 0; // bumped by every failing property

	////////////////////////////////////////////////////////////////////////////
	// fetch stage properties
	////////////////////////////////////////////////////////////////////////////

	// flush lands one edge after the late redirect
	flushAfterRedirect: assert property (@(posedge clk) disable iff (!rstN)
		exRedirect.valid |=> !idPacket.valid)
		else begin
			$error("idPacket valid in the cycle after exRedirect");
			failCount++;
		end

	// a late redirect overrides stall, so only plain stall cycles count
	pcHeldOnStall: assert property (@(posedge clk) disable iff (!rstN)
		(stall && !exRedirect.valid) |=> $stable(pc))
		else begin
			$error("pc moved while stall was high");
			failCount++;
		end

	// stall freezes the old packet, otherwise a conflict gives a bubble
	noValidOnConflict: assert property (@(posedge clk) disable iff (!rstN)
		(memConflict && !stall) |=> !idPacket.valid)
		else begin
			$error("conflict cycle produced a valid packet");
			failCount++;
		end

endmodule

// File: dv/fetchTb.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetchTb;

	localparam int B_IDX         = 5;  // word holding the forward B
	localparam int B_DEST        = 10; // first word after the gap
	localparam int PROG_END      = 14; // one past the last loaded word
	localparam int RESET_TIMEOUT = 40;
	localparam int DRAIN_TIMEOUT = 20;

	// table row with the cycle inputs and the packet expected after the edge
	typedef struct packed {
		logic                   stall;
		logic                   memConflict;
		fetch_pkg::redirectT    redirect;
		fetch_pkg::fetchPacketT expPacket;
	} rowT;

	logic                   clk;
	logic                   rstN;
	logic                   stall;
	logic                   memConflict;
	logic                   progWe;
	logic [`IMEM_AW-1:0]    progAddr;
	logic [15:0]            progData;
	fetch_pkg::redirectT    exRedirect;
	fetch_pkg::fetchPacketT idPacket;

	logic [15:0] progImage [0:`IMEM_DEPTH-1]; // testbench copy of the program
	int          loadOrder [$];                // word indices written
	rowT         rows [$];
	string       rowNames [$];

	fetchTop UUT (
		.clk         (clk),
		.rstN        (rstN),
		.stall       (stall),
		.memConflict (memConflict),
		.progWe      (progWe),
		.progAddr    (progAddr),
		.progData    (progData),
		.exRedirect  (exRedirect),
		.idPacket    (idPacket)
	);

	bind fetchTop fetch_asserts uFetchAsserts (
		.clk         (clk),
		.rstN        (rstN),
		.stall       (stall),
		.memConflict (memConflict),
		.exRedirect  (exRedirect),
		.pc          (pc),
		.idPacket    (idPacket)
	);

	////////////////////////////////////////////////////////////////////////////
	// clock and reset
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		rstN = 1'b0;
		repeat (10) @(posedge clk);
		#1 rstN = 1'b1;
	end

	// a bound property failure ends the run at once
	always @(UUT.uFetchAsserts.failCount) begin
		if (UUT.uFetchAsserts.failCount != 0) begin
			$display("a bound fetch assertion failed");
			$display("TB FAILED");
			$fatal(1, "bound assertion failure");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic checkPacket(input string name, input fetch_pkg::fetchPacketT exp);
		assert (idPacket === exp) else begin
			$display("FAILED %s expected %h actual %h", name, exp, idPacket);
			$display("TB FAILED");
			$fatal(1, "idPacket mismatch");
		end
	endtask

	// pcWord and instrWord count words
	// a negative instrWord stands for the nop word
	task automatic addRow(input string name, input logic st, input logic cf,
			input logic rv, input int rtWord, input logic ev, input int pcWord,
			input int instrWord);
		rowT r;
		r.stall           = st;
		r.memConflict     = cf;
		r.redirect.valid  = rv;
		r.redirect.target = 16'(rtWord * 4);
		r.expPacket.valid = ev;
		r.expPacket.pc    = 16'(pcWord * 4);
		r.expPacket.instr = (instrWord < 0) ? `NOP_WORD : progImage[instrWord];
		rows.push_back(r);
		rowNames.push_back(name);
	endtask

	// random filler never carries opB so only word B_IDX redirects
	task automatic buildProgram();
		logic [15:0] w;
		for (int i = 0; i < 8; i++) begin
			loadOrder.push_back(i);
		end
		for (int i = B_DEST; i < PROG_END; i++) begin
			loadOrder.push_back(i); // after the gap
		end
		foreach (loadOrder[k]) begin
			w = 16'($urandom);
			if (w[15:11] == fetch_pkg::opB) begin
				w[15:11] = fetch_pkg::opAddiu;
			end
			progImage[loadOrder[k]] = w;
		end
		// B imm counts words from the next pc
		progImage[B_IDX] = {fetch_pkg::opB, 11'(B_DEST - B_IDX - 1)};
	endtask

	task automatic loadProgram(); // stall is already high
		foreach (loadOrder[k]) begin
			progWe   = 1'b1;
			progAddr = `IMEM_AW'(loadOrder[k]);
			progData = progImage[loadOrder[k]];
			@(posedge clk);
			#1;
		end
		progWe = 1'b0;
	endtask

	task automatic waitResetRelease();
		int cycles;
		cycles = 0;
		while (rstN !== 1'b1) begin
			if (cycles == RESET_TIMEOUT) begin
				$display("timeout while waiting for reset to be released");
				$display("TB FAILED");
				$fatal(1, "reset timeout");
			end
			@(posedge clk);
			cycles++;
		end
		#1;
	endtask

	// run on until the first packet past the loaded program shows up
	task automatic drainToEnd();
		int cycles;
		cycles = 0;
		stall       = 1'b0;
		memConflict = 1'b0;
		exRedirect  = '0;
		while (idPacket.pc !== 16'(PROG_END * 4)) begin
			if (cycles == DRAIN_TIMEOUT) begin
				$display("timeout while waiting for fetch to run past the program");
				$display("TB FAILED");
				$fatal(1, "drain timeout");
			end
			@(posedge clk);
			#1;
			cycles++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int                     seedDummy;
		fetch_pkg::fetchPacketT resetPacket;
		fetch_pkg::fetchPacketT endPacket;
		stall       = 1'b1; // held through reset and the load
		memConflict = 1'b0;
		progWe      = 1'b0;
		progAddr    = '0;
		progData    = '0;
		exRedirect  = '0;
		seedDummy   = $urandom(67309);

		buildProgram();
		waitResetRelease();
		resetPacket = {1'b0, `RESET_PC, `NOP_WORD};
		checkPacket("reset", resetPacket);
		loadProgram();
		checkPacket("afterLoad", resetPacket); // stall kept IF/ID frozen

		addRow("seq0",        0, 0, 0, 0,  1, 0,      0);
		addRow("seq1",        0, 0, 0, 0,  1, 1,      1);
		addRow("conflict",    0, 1, 0, 0,  0, 2,      -1); // bubble while pc holds
		addRow("resume",      0, 0, 0, 0,  1, 2,      2);
		addRow("seq3",        0, 0, 0, 0,  1, 3,      3);
		addRow("stall0",      1, 0, 0, 0,  1, 3,      3);
		addRow("stall1",      1, 0, 0, 0,  1, 3,      3);
		addRow("stall2",      1, 0, 0, 0,  1, 3,      3);
		addRow("afterStall",  0, 0, 0, 0,  1, 4,      4);
		addRow("fetchB",      0, 0, 0, 0,  1, B_IDX,  B_IDX);
		addRow("bTarget",     0, 0, 0, 0,  1, B_DEST, B_DEST); // no nop after B
		addRow("post1",       0, 0, 0, 0,  1, 11,     11);
		addRow("post2",       0, 0, 0, 0,  1, 12,     12);
		addRow("post3",       0, 0, 0, 0,  1, 13,     13);
		addRow("pastEnd0",    0, 0, 0, 0,  1, 14,     -1); // beyond progLen
		addRow("pastEnd1",    0, 0, 0, 0,  1, 15,     -1);
		addRow("redirect",    0, 0, 1, 1,  0, 1,      -1); // flush carries target
		addRow("redirTgt",    0, 0, 0, 0,  1, 1,      1);
		addRow("redirNext",   0, 0, 0, 0,  1, 2,      2);
		addRow("redirToB",    0, 0, 1, B_IDX, 0, B_IDX, -1);
		addRow("conflictOnB", 0, 1, 0, 0,  0, B_IDX,  -1); // bubble on the B word
		addRow("takeB",       0, 0, 0, 0,  1, B_IDX,  B_IDX);
		addRow("bTarget2",    0, 0, 0, 0,  1, B_DEST, B_DEST);

		foreach (rows[i]) begin
			stall       = rows[i].stall;
			memConflict = rows[i].memConflict;
			exRedirect  = rows[i].redirect;
			@(posedge clk);
			#1; // outputs have settled by now
			checkPacket(rowNames[i], rows[i].expPacket);
		end

		drainToEnd();
		endPacket = {1'b1, 16'(PROG_END * 4), `NOP_WORD};
		checkPacket("drainEnd", endPacket);

		$display("TB PASSED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+common
common/fetch_pkg.sv
fetch/pcGen.sv
fetch/instructionMemory.sv
fetch/branchPredecode.sv
fetch/ifIdReg.sv
hdl/fetchTop.sv
dv/fetch_asserts.sv
dv/fetchTb.sv
